// File: evict_select.sv
// Victim way selection
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

module evict_select (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  llc_tag_pkg::way_vec_t valid_i,
  input  llc_tag_pkg::way_vec_t lock_i,
  input  logic                  commit_i,
  output llc_tag_pkg::way_vec_t victim_o
);
  import llc_tag_pkg::*;

  // Round-robin replacement pointer
  way_num_t ptr_q;
  way_num_t victim_num;
  // Victim came from the pointer search, set is full
  logic     use_ptr;
  logic     found;
  way_vec_t free_vec;
  int       idx;

  always_comb begin
    victim_o   = '0;
    victim_num = '0;
    use_ptr    = 1'b0;
    found      = 1'b0;
    idx        = 0;
    free_vec   = ~valid_i & ~lock_i;
    // Lowest free and unlocked way wins
    for (int w = 0; w < `LLC_TAG_WAYS; w++) begin
      if (free_vec[w] && !found) begin
        victim_o[w] = 1'b1;
        victim_num  = way_num_t'(w);
        found       = 1'b1;
      end
    end
    // Set full, walk from the pointer and wrap
    if (!found) begin
      use_ptr = 1'b1;
      for (int k = 0; k < `LLC_TAG_WAYS; k++) begin
        idx = (int'(ptr_q) + k) % `LLC_TAG_WAYS;
        if (!lock_i[idx] && !found) begin
          victim_o[idx] = 1'b1;
          victim_num    = way_num_t'(idx);
          found         = 1'b1;
        end
      end
    end
  end

  // Pointer steps past the replaced way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (commit_i && use_ptr) begin
      ptr_q <= way_num_t'((int'(victim_num) + 1) % `LLC_TAG_WAYS);
    end
  end

  a_victim_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    !(&lock_i) |-> $onehot(victim_o))
    else $error("evict_select victim is not one-hot");

endmodule

`default_nettype wire

// File: llc_tag_config.svh
// LLC tag store geometry
`ifndef LLC_TAG_CONFIG_SVH
`define LLC_TAG_CONFIG_SVH

// Associativity of the cache
`define LLC_TAG_WAYS 4

// Number of sets held in the tag memory
`define LLC_TAG_SETS 16

// Set index width, log2 of the set count
`define LLC_TAG_INDEX_W 4

// Stored tag width
`define LLC_TAG_TAG_W 10

// Binary way number width, log2 of the way count
`define LLC_TAG_WAY_W 2

// Cycles from a read strobe to rvalid on the tag memory
// Must be at least one
`define LLC_TAG_RAM_LATENCY 2

`endif

// File: llc_tag_pkg.sv
// LLC tag store types
`default_nettype none

`include "llc_tag_config.svh"

package llc_tag_pkg;

  // Operation carried by a request
  typedef enum logic {
    OP_LOOKUP,
    OP_FLUSH
  } tag_op_e;

  // One bit per way, used as one-hot selector or as mask
  typedef logic [`LLC_TAG_WAYS-1:0] way_vec_t;

  typedef logic [`LLC_TAG_TAG_W-1:0]   tag_t;
  typedef logic [`LLC_TAG_INDEX_W-1:0] index_t;
  typedef logic [`LLC_TAG_WAY_W-1:0]   way_num_t;

  // Content of one tag memory slot
  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  // Request payload
  // dirty marks a write access, flush_way only matters for OP_FLUSH
  typedef struct packed {
    tag_op_e  op;
    index_t   index;
    tag_t     tag;
    logic     dirty;
    way_num_t flush_way;
  } tag_req_t;

  // Result payload
  // way is one-hot: hit way, victim way or flushed way
  typedef struct packed {
    logic     hit;
    logic     evict;
    way_vec_t way;
    tag_t     evict_tag;
  } tag_res_t;

endpackage

`default_nettype wire

// File: llc_tag_store.f
+incdir+.
llc_tag_pkg.sv
tag_ram_if.sv
tag_ram.sv
tag_match.sv
evict_select.sv
tag_ctrl.sv
llc_tag_store.sv
tb_llc_tag_store.sv

// File: llc_tag_store.sv
// LLC tag store top level
`timescale 1ns/1ps
`default_nettype none

module llc_tag_store (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Ways reserved as scratchpad
  input  llc_tag_pkg::way_vec_t spm_lock_i,
  // Request handshake
  input  llc_tag_pkg::tag_req_t req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  // Result handshake
  output llc_tag_pkg::tag_res_t res_o,
  output logic                  valid_o,
  input  logic                  ready_i
);
  import llc_tag_pkg::*;

  way_vec_t hit;
  way_vec_t valid_vec;
  way_vec_t dirty_vec;
  way_vec_t victim;
  logic     commit;
  tag_t     req_tag;

  // Memory access bundle between sequencer and storage
  tag_ram_if ram_if ();

  tag_ram u_tag_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ram     (ram_if.mem)
  );

  // Compare runs on the held read data
  tag_match u_tag_match (
    .entries_i (ram_if.rdata),
    .tag_i     (req_tag),
    .lock_i    (spm_lock_i),
    .hit_o     (hit),
    .valid_o   (valid_vec),
    .dirty_o   (dirty_vec)
  );

  evict_select u_evict_select (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .valid_i  (valid_vec),
    .lock_i   (spm_lock_i),
    .commit_i (commit),
    .victim_o (victim)
  );

  tag_ctrl u_tag_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .spm_lock_i  (spm_lock_i),
    .ram         (ram_if.ctrl),
    .hit_i       (hit),
    .valid_vec_i (valid_vec),
    .dirty_vec_i (dirty_vec),
    .victim_i    (victim),
    .commit_o    (commit),
    .res_o       (res_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .req_tag_o   (req_tag)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the LLC tag store testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=sim_llc_tag_store
PASS_MSG="All checks passed"

if ! verilator --binary --timing --assert \
    --top-module tb_llc_tag_store \
    -f llc_tag_store.f -o "$SIM"; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: tag_ctrl.sv
// Tag store operation sequencer
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

module tag_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Request side
  input  llc_tag_pkg::tag_req_t req_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  input  llc_tag_pkg::way_vec_t spm_lock_i,
  // Tag memory
  tag_ram_if.ctrl               ram,
  // From tag_match
  input  llc_tag_pkg::way_vec_t hit_i,
  input  llc_tag_pkg::way_vec_t valid_vec_i,
  input  llc_tag_pkg::way_vec_t dirty_vec_i,
  // From and to evict_select
  input  llc_tag_pkg::way_vec_t victim_i,
  output logic                  commit_o,
  // Result side
  output llc_tag_pkg::tag_res_t res_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output llc_tag_pkg::tag_t     req_tag_o
);
  import llc_tag_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_READ,
    ST_HOLD_RESULT
  } ctrl_state_e;

  ctrl_state_e state_q, state_d;
  tag_req_t    req_q;
  tag_res_t    res_q, res_d;
  logic        accept;
  logic        res_hsk;
  logic        lookup_hit;
  way_vec_t    sel_way;
  tag_entry_t  sel_entry;

  // Only one request in flight
  assign ready_o   = (state_q == ST_IDLE);
  assign valid_o   = (state_q == ST_HOLD_RESULT);
  assign accept    = valid_i && ready_o;
  assign res_hsk   = valid_o && ready_i;
  assign res_o     = res_q;
  assign req_tag_o = req_q.tag;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE:        if (accept)     state_d = ST_WAIT_READ;
      ST_WAIT_READ:   if (ram.rvalid) state_d = ST_HOLD_RESULT;
      ST_HOLD_RESULT: if (ready_i)    state_d = ST_IDLE;
      default:        state_d = ST_IDLE;
    endcase
  end

  // Result from the read set
  always_comb begin
    lookup_hit = |hit_i;
    if (req_q.op == OP_FLUSH) begin
      sel_way = way_vec_t'(1) << req_q.flush_way;
    end else if (lookup_hit) begin
      sel_way = hit_i;
    end else begin
      sel_way = victim_i;
    end
    // One-hot mux of the selected entry
    sel_entry = '0;
    for (int w = 0; w < `LLC_TAG_WAYS; w++) begin
      if (sel_way[w]) begin
        sel_entry = sel_entry | ram.rdata[w];
      end
    end
    res_d.hit       = (req_q.op == OP_LOOKUP) && lookup_hit;
    res_d.way       = sel_way;
    // Write-back needed only for a valid dirty line leaving the cache
    res_d.evict     = !res_d.hit && |(sel_way & valid_vec_i & dirty_vec_i);
    res_d.evict_tag = res_d.hit ? '0 : sel_entry.tag;
  end

  // Read on accept, update at the result handshake
  // rdata is still the held set here, so dirty_vec_i is the old state
  always_comb begin
    ram.rd_en = accept;
    ram.index = (state_q == ST_IDLE) ? req_i.index : req_q.index;
    ram.wr_en = '0;
    ram.wdata = '0;
    commit_o  = 1'b0;
    if (res_hsk) begin
      unique case (req_q.op)
        // Flush clears the slot
        OP_FLUSH: ram.wr_en = res_q.way;
        OP_LOOKUP: begin
          if (res_q.hit) begin
            // Set dirty only on a write hitting a clean line
            if (req_q.dirty && !(|(dirty_vec_i & res_q.way))) begin
              ram.wr_en = res_q.way;
              ram.wdata = '{valid: 1'b1, dirty: 1'b1, tag: req_q.tag};
            end
          end else begin
            // Install the new tag in the victim slot
            ram.wr_en = res_q.way;
            ram.wdata = '{valid: 1'b1, dirty: req_q.dirty, tag: req_q.tag};
            commit_o  = 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request and result payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if ((state_q == ST_WAIT_READ) && ram.rvalid) begin
      res_q <= res_d;
    end
  end

  a_res_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (valid_o && !ready_i) |=> (valid_o && $stable(res_o)))
    else $error("tag_ctrl dropped or changed a result before ready_i");

  a_no_lookup_all_locked: assert property (@(posedge clk_i) disable iff (reset_i)
    (accept && (req_i.op == OP_LOOKUP)) |-> !(&spm_lock_i))
    else $error("lookup accepted with every way locked");

endmodule

`default_nettype wire

// File: tag_match.sv
// Per-way tag compare
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

module tag_match (
  input  llc_tag_pkg::tag_entry_t [`LLC_TAG_WAYS-1:0] entries_i,
  input  llc_tag_pkg::tag_t                           tag_i,
  input  llc_tag_pkg::way_vec_t                       lock_i,
  output llc_tag_pkg::way_vec_t                       hit_o,
  output llc_tag_pkg::way_vec_t                       valid_o,
  output llc_tag_pkg::way_vec_t                       dirty_o
);

  // Status bits straight from the stored entries
  // Locked scratchpad ways are excluded from hits only
  always_comb begin
    for (int w = 0; w < `LLC_TAG_WAYS; w++) begin
      valid_o[w] = entries_i[w].valid;
      dirty_o[w] = entries_i[w].dirty;
      // Valid, usable as cache and same tag
      hit_o[w]   = entries_i[w].valid && !lock_i[w] && (entries_i[w].tag == tag_i);
    end
  end

  // A tag is installed only on a miss, so no set holds it twice
  a_hit_onehot: assert final ($onehot0(hit_o))
    else $error("tag_match found the tag in more than one way");

endmodule

`default_nettype wire

// File: tag_ram.sv
// Tag storage array
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

module tag_ram (
  input logic    clk_i,
  input logic    reset_i,
  tag_ram_if.mem ram
);
  import llc_tag_pkg::*;

  // Storage, one row per set holding every way
  tag_entry_t [`LLC_TAG_WAYS-1:0] mem_q [`LLC_TAG_SETS];

  // Read delay line, data stage loads only behind a valid token
  tag_entry_t [`LLC_TAG_WAYS-1:0] pipe_data_q [`LLC_TAG_RAM_LATENCY];
  logic [`LLC_TAG_RAM_LATENCY-1:0] pipe_valid_q;

  // Masked write, every slot invalid after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `LLC_TAG_SETS; s++) begin
        mem_q[s] <= '0;
      end
    end else begin
      for (int w = 0; w < `LLC_TAG_WAYS; w++) begin
        if (ram.wr_en[w]) begin
          mem_q[ram.index][w] <= ram.wdata;
        end
      end
    end
  end

  // First stage samples the addressed set
  // Later stages move data only with the token, so rdata stays put after rvalid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pipe_valid_q <= '0;
      for (int k = 0; k < `LLC_TAG_RAM_LATENCY; k++) begin
        pipe_data_q[k] <= '0;
      end
    end else begin
      pipe_valid_q[0] <= ram.rd_en;
      if (ram.rd_en) begin
        pipe_data_q[0] <= mem_q[ram.index];
      end
      for (int k = 1; k < `LLC_TAG_RAM_LATENCY; k++) begin
        pipe_valid_q[k] <= pipe_valid_q[k-1];
        if (pipe_valid_q[k-1]) begin
          pipe_data_q[k] <= pipe_data_q[k-1];
        end
      end
    end
  end

  assign ram.rdata  = pipe_data_q[`LLC_TAG_RAM_LATENCY-1];
  assign ram.rvalid = pipe_valid_q[`LLC_TAG_RAM_LATENCY-1];

  // Sequencer keeps read and write-back in separate cycles
  a_no_rd_wr_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ram.rd_en && |ram.wr_en))
    else $error("tag_ram read and write in the same cycle");

endmodule

`default_nettype wire

// File: tag_ram_if.sv
// Tag memory access bundle
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

interface tag_ram_if;
  import llc_tag_pkg::*;

  // Read strobe for all ways of one set
  logic rd_en;
  // Per-way write mask, write lands on the clock edge of this cycle
  way_vec_t wr_en;
  // Set addressed by both read and write
  index_t index;
  tag_entry_t wdata;
  // All ways of the set that was read
  // Holds its value from rvalid until the next read completes
  tag_entry_t [`LLC_TAG_WAYS-1:0] rdata;
  // Pulses exactly LLC_TAG_RAM_LATENCY cycles after rd_en
  logic rvalid;

  // Sequencer side
  modport ctrl (output rd_en, wr_en, index, wdata, input rdata, rvalid);

  // Storage side
  modport mem (input rd_en, wr_en, index, wdata, output rdata, rvalid);

endinterface

`default_nettype wire

// File: tb_llc_tag_store.sv
// LLC tag store testbench
`timescale 1ns/1ps
`default_nettype none

`include "llc_tag_config.svh"

module tb_llc_tag_store;
  import llc_tag_pkg::*;

  localparam int N_REQ          = 600;
  localparam int TIMEOUT_CYCLES = N_REQ * 12;
  // Result appears in the third cycle after the request cycle
  localparam int RESULT_DELAY   = `LLC_TAG_RAM_LATENCY + 1;
  localparam int WAYS           = `LLC_TAG_WAYS;
  localparam int POOL           = 8;

  logic     clk_i;
  logic     reset_i;
  way_vec_t spm_lock_i;
  tag_req_t req_i;
  logic     valid_i;
  logic     ready_o;
  tag_res_t res_o;
  logic     valid_o;
  logic     ready_i;

  // Reference state, updated at each result handshake
  tag_entry_t model_mem [`LLC_TAG_SETS][WAYS];
  int         model_ptr;
  tag_t       tag_pool [POOL];

  // Prediction for the request in flight
  tag_res_t exp_res;
  logic     exp_from_ptr;
  int       exp_way;

  int cycle_count = 0;
  int n_hits      = 0;
  int n_evicts    = 0;
  int n_flushes   = 0;

  llc_tag_store dut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .spm_lock_i (spm_lock_i),
    .req_i      (req_i),
    .valid_i    (valid_i),
    .ready_o    (ready_o),
    .res_o      (res_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_res(input string name, input tag_res_t got, input tag_res_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // Tag already stored in a locked way of the set
  function automatic logic held_in_locked(input tag_req_t req, input way_vec_t lock);
    logic found;
    found = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (lock[w] && model_mem[req.index][w].valid &&
          model_mem[req.index][w].tag == req.tag) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  // Expected result from the hit, victim and flush rules
  task automatic predict_result(input tag_req_t req, input way_vec_t lock);
    tag_entry_t e;
    int         w;
    exp_res      = '0;
    exp_from_ptr = 1'b0;
    exp_way      = -1;
    if (req.op == OP_FLUSH) begin
      exp_way = int'(req.flush_way);
    end else begin
      // Hit needs valid, unlocked, same tag
      for (w = 0; w < WAYS; w++) begin
        e = model_mem[req.index][w];
        if (e.valid && !lock[w] && e.tag == req.tag) begin
          exp_way     = w;
          exp_res.hit = 1'b1;
        end
      end
      // Miss takes the lowest free unlocked way
      if (!exp_res.hit) begin
        for (w = WAYS - 1; w >= 0; w--) begin
          if (!model_mem[req.index][w].valid && !lock[w]) begin
            exp_way = w;
          end
        end
      end
      // Full set, first unlocked way from the pointer
      if (!exp_res.hit && exp_way < 0) begin
        exp_from_ptr = 1'b1;
        for (int k = WAYS - 1; k >= 0; k--) begin
          w = (model_ptr + k) % WAYS;
          if (!lock[w]) begin
            exp_way = w;
          end
        end
      end
    end
    exp_res.way[exp_way] = 1'b1;
    if (!exp_res.hit) begin
      e                 = model_mem[req.index][exp_way];
      exp_res.evict     = e.valid && e.dirty;
      exp_res.evict_tag = e.tag;
    end
  endtask

  // Same update the DUT makes at the result handshake
  task automatic apply_writeback(input tag_req_t req);
    if (req.op == OP_FLUSH) begin
      model_mem[req.index][exp_way] = '0;
      n_flushes++;
    end else if (exp_res.hit) begin
      if (req.dirty) begin
        model_mem[req.index][exp_way].dirty = 1'b1;
      end
      n_hits++;
    end else begin
      model_mem[req.index][exp_way] = '{valid: 1'b1, dirty: req.dirty, tag: req.tag};
      if (exp_from_ptr) begin
        model_ptr = (exp_way + 1) % WAYS;
      end
    end
    if (exp_res.evict) begin
      n_evicts++;
    end
  endtask

  task automatic make_request(output tag_req_t req);
    int tries;
    req           = '0;
    req.op        = ($urandom % 5 == 0) ? OP_FLUSH : OP_LOOKUP;
    req.index     = index_t'($urandom % `LLC_TAG_SETS);
    req.tag       = tag_pool[$urandom % POOL];
    req.dirty     = 1'($urandom % 2);
    req.flush_way = way_num_t'($urandom % WAYS);
    // A second copy next to a locked one would hit twice after unlock
    tries = 0;
    while (req.op == OP_LOOKUP && held_in_locked(req, spm_lock_i) && tries < 16) begin
      req.tag = tag_pool[$urandom % POOL];
      tries++;
    end
    if (held_in_locked(req, spm_lock_i)) begin
      req.op = OP_FLUSH;
    end
  endtask

  // Only called while the DUT is idle, never locks every way
  task automatic change_lock();
    way_vec_t lock;
    if ($urandom % 8 == 0) begin
      lock = ($urandom % 2 == 0) ? '0 : way_vec_t'($urandom);
      if (&lock) begin
        lock = '0;
      end
      spm_lock_i = lock;
    end
  endtask

  task automatic run_request();
    tag_req_t req;
    logic     handshake;
    // Idle gap with ready_o expected high
    repeat ($urandom % 3) begin
      ready_i = 1'($urandom % 2);
      @(posedge clk_i);
      #1;
      check_bit("ready_o", ready_o, 1'b1);
    end
    change_lock();
    make_request(req);
    predict_result(req, spm_lock_i);
    check_bit("ready_o", ready_o, 1'b1);
    req_i   = req;
    valid_i = 1'b1;
    // Accept edge, then fixed read latency
    for (int cycles = 1; cycles <= RESULT_DELAY; cycles++) begin
      @(posedge clk_i);
      #1;
      check_bit("valid_o", valid_o, cycles == RESULT_DELAY);
      check_bit("ready_o", ready_o, 1'b0);
      valid_i = 1'b0;
      ready_i = 1'($urandom % 2);
    end
    // Result must stay put under back-pressure
    handshake = 1'b0;
    while (!handshake) begin
      check_res("res_o", res_o, exp_res);
      handshake = ready_i;
      @(posedge clk_i);
      #1;
      check_bit("ready_o", ready_o, handshake);
      check_bit("valid_o", valid_o, !handshake);
      ready_i = 1'($urandom % 2);
    end
    apply_writeback(req);
  endtask

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: requests not done after %0d cycles", cycle_count));
    end
  end

  initial begin
    void'($urandom(32'h571));
    reset_i    = 1'b1;
    valid_i    = 1'b0;
    ready_i    = 1'b0;
    req_i      = '0;
    spm_lock_i = '0;
    model_ptr  = 0;
    for (int s = 0; s < `LLC_TAG_SETS; s++) begin
      for (int w = 0; w < WAYS; w++) begin
        model_mem[s][w] = '0;
      end
    end
    // Small tag pool so sets fill and lines hit
    for (int i = 0; i < POOL; i++) begin
      tag_pool[i] = tag_t'($urandom);
    end
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_bit("ready_o", ready_o, 1'b1);
    check_bit("valid_o", valid_o, 1'b0);
    for (int n = 0; n < N_REQ; n++) begin
      run_request();
    end
    $display("%0d requests, %0d hits, %0d write-backs, %0d flushes",
             N_REQ, n_hits, n_evicts, n_flushes);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
